// File: sim.f
+incdir+bench
rtl/bus_pkg.sv
rtl/uart_pkg.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
bench/tb_uart.sv

// File: Makefile
# Verilator simulation and lint for the UART peripheral

VERILATOR ?= verilator
TOP       ?= tb_uart
RTL_TOP   ?= uart_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only
PASS_MSG  ?= Done: no errors
RTL_FILES ?= rtl/bus_pkg.sv rtl/uart_pkg.sv rtl/uart_regs.sv rtl/uart_tx.sv \
             rtl/uart_rx.sv rtl/uart_top.sv

SOURCES := $(RTL_FILES) bench/tb_uart.sv bench/tb_uart_tasks.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_uart_tasks.svh
// UART testbench tasks
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// ------------------------------
// Compare tasks
// ------------------------------

task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
        $display("mismatch at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        n_mismatch++;
    end
endtask

task automatic check_word(input wb_data_t got, input wb_data_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
        $display("mismatch at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        n_mismatch++;
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
        $display("mismatch at %0d ns: %s, got %b expected %b", $time, what, got, exp);
        n_mismatch++;
    end
endtask

// ------------------------------
// Wishbone master
// ------------------------------

function automatic wb_addr_t reg_addr(input uart_reg_e r);
    return wb_addr_t'({r, 2'b00});
endfunction

// Holds the request until ack and drops it in the cycle after
task automatic bus_cycle(input logic we, input uart_reg_e r, input wb_data_t wdata,
                         output wb_data_t rdata);
    int unsigned n;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= reg_addr(r);
    wb_wdata <= wdata;
    n = 0;
    do begin
        @(posedge clk);
        n++;
    end while (wb_ack !== 1'b1 && n < ack_limit);
    if (wb_ack !== 1'b1) begin
        $display("error at %0d ns: slave never acknowledged access to %s", $time, r.name());
        n_other++;
    end
    rdata         = wb_rdata;
    last_ack_time = $time;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
endtask

task automatic wb_write(input uart_reg_e r, input wb_data_t val);
    wb_data_t unused;
    bus_cycle(1'b1, r, val, unused);
endtask

task automatic wb_read(input uart_reg_e r, output wb_data_t val);
    bus_cycle(1'b0, r, '0, val);
endtask

// ------------------------------
// Serial line
// ------------------------------

// Frame into rxd at the current divisor
task automatic serial_send(input uart_byte_t data, input logic stop);
    uart_byte_t shift;
    shift = data;
    @(posedge clk);
    rxd <= 1'b0;
    repeat (bit_div) @(posedge clk);
    repeat (8) begin
        rxd <= shift[0];
        shift = shift >> 1;
        repeat (bit_div) @(posedge clk);
    end
    rxd <= stop;
    repeat (bit_div) @(posedge clk);
    rxd <= 1'b1;
endtask

// Samples bit middles 5 ns off the clock edges
task automatic serial_capture(output uart_byte_t data, output logic [1:0] stop,
                              output time start_t);
    @(negedge txd);
    start_t = $time;
    #(bit_div * clk_period / 2 + 5);
    check_bit(txd, 1'b0, "tx start bit");
    data = '0;
    repeat (8) begin
        #(bit_div * clk_period);
        data = {txd, data[7:1]};
    end
    #(bit_div * clk_period);
    stop[0] = txd;
    #(bit_div * clk_period);
    stop[1] = txd;
endtask

task automatic wait_irq(input string what);
    int unsigned n;
    n = 0;
    while (irq !== 1'b1 && n < irq_limit) begin
        @(posedge clk);
        n++;
    end
    if (irq !== 1'b1) begin
        $display("error at %0d ns: interrupt never rose during %s", $time, what);
        n_other++;
    end
endtask

`endif

// File: bench/tb_uart.sv
// UART peripheral testbench
`timescale 1ns/10ps

module tb_uart;

    import bus_pkg::*;
    import uart_pkg::*;

    localparam int unsigned div_w      = 16;
    localparam int unsigned clk_period = 20;
    // Frames over all tests and the largest divisor they run at
    localparam int unsigned n_frames   = 9;
    localparam int unsigned max_div    = 8;
    localparam int unsigned ack_limit  = 14 * max_div;
    localparam int unsigned irq_limit  = 12 * max_div;
    localparam int unsigned watchdog_ns =
        n_frames * 12 * max_div * clk_period + 600 * clk_period;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    wb_data_t    wb_wdata;
    wb_data_t    wb_rdata;
    logic        wb_ack;
    logic        rxd;
    logic        txd;
    logic        irq;

    int unsigned n_checks;
    int unsigned n_mismatch;
    int unsigned n_other;
    int unsigned bit_div;
    logic [31:0] lcg_state;
    time         last_ack_time;

    `include "tb_uart_tasks.svh"

    uart_top #(
        .div_w      (div_w)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_wdata),
        .wb_dat_o   (wb_rdata),
        .wb_ack_o   (wb_ack),
        .uart_rxd_i (rxd),
        .uart_txd_o (txd),
        .uart_irq_o (irq)
    );

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic uart_byte_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // Status as the register map defines it
    function automatic wb_data_t expected_status(input logic rx_rdy, input logic ferr,
                                                 input logic tx_idle);
        uart_byte_t st;
        st               = '0;
        st[st_rx_ready]  = rx_rdy;
        st[st_frame_err] = ferr;
        st[st_tx_empty]  = tx_idle;
        st[st_tx_idle]   = tx_idle;
        return wb_data_t'(st);
    endfunction

    task automatic set_divisor(input int unsigned d);
        wb_write(reg_baud, wb_data_t'(d));
        bit_div = d;
    endtask

    task automatic write_readback(input uart_reg_e r, input wb_data_t val,
                                  input int unsigned width);
        wb_data_t rd;
        wb_data_t mask;
        mask = (wb_data_t'(1) << width) - wb_data_t'(1);
        wb_write(r, val);
        wb_read(r, rd);
        check_word(rd, val & mask, {r.name(), " readback"});
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic reset_and_register_access();
        wb_data_t rd;
        wb_read(reg_baud, rd);
        check_word(rd, wb_data_t'(baud_reset), "baud after reset");
        wb_read(reg_scratch, rd);
        check_word(rd, wb_data_t'(scratch_reset), "scratch after reset");
        wb_read(reg_lstatus, rd);
        check_word(rd, expected_status(1'b0, 1'b0, 1'b1), "status after reset");
        check_bit(irq, 1'b0, "irq after reset");
        check_bit(txd, 1'b1, "txd after reset");
        write_readback(reg_scratch, 32'h1234_565a, 8);
        write_readback(reg_ie, 32'hc3c3_c3a4, 8);
        write_readback(reg_lctrl, 32'h0000_01fb, 8);
        write_readback(reg_baud, 32'h00ab_0123, div_w);
        // Status is read only
        wb_write(reg_lstatus, 32'hffff_ffff);
        wb_read(reg_lstatus, rd);
        check_word(rd, expected_status(1'b0, 1'b0, 1'b1), "status after write");
        wb_write(reg_ie, '0);
        wb_write(reg_lctrl, '0);
        set_divisor(baud_reset);
        check_bit(irq, 1'b0, "irq with ie cleared");
    endtask

    task automatic transmit_one_stop();
        uart_byte_t b;
        uart_byte_t got;
        logic [1:0] stop;
        time        t0;
        wb_data_t   rd;
        b = next_random();
        fork
            wb_write(reg_data, wb_data_t'(b));
            serial_capture(got, stop, t0);
        join
        check_byte(got, b, "tx byte with one stop bit");
        check_bit(stop[0], 1'b1, "tx stop bit");
        // Capture ends inside the second stop bit period, one stop bit means idle by now
        wb_read(reg_lstatus, rd);
        check_word(rd, expected_status(1'b0, 1'b0, 1'b1), "tx idle after one stop bit");
    endtask

    task automatic transmit_two_stop_backpressure();
        uart_byte_t b0;
        uart_byte_t b1;
        uart_byte_t got0;
        uart_byte_t got1;
        logic [1:0] stop0;
        logic [1:0] stop1;
        time        t0;
        time        t1;
        time        t_ack;
        time        frame_end;
        b0 = next_random();
        b1 = next_random();
        wb_write(reg_lctrl, wb_data_t'(1) << lc_two_stop);
        fork
            begin
                wb_write(reg_data, wb_data_t'(b0));
                wb_write(reg_data, wb_data_t'(b1));
                t_ack = last_ack_time;
            end
            begin
                serial_capture(got0, stop0, t0);
                serial_capture(got1, stop1, t1);
            end
        join
        // Start, eight data and two stop bits
        frame_end = t0 + time'(11 * bit_div * clk_period);
        check_byte(got0, b0, "first byte with two stop bits");
        check_byte(got1, b1, "second byte with two stop bits");
        check_bit(&stop0, 1'b1, "first frame stop bits");
        check_bit(&stop1, 1'b1, "second frame stop bits");
        check_bit(t_ack >= frame_end, 1'b1, "second ack held until first frame ends");
        check_bit(t1 >= frame_end, 1'b1, "second frame after two stop bits");
        wb_write(reg_lctrl, '0);
    endtask

    task automatic receive_with_irq();
        uart_byte_t b;
        wb_data_t   rd;
        b = next_random();
        wb_write(reg_ie, wb_data_t'(1) << st_rx_ready);
        serial_send(b, 1'b1);
        wait_irq("receive");
        wb_read(reg_lstatus, rd);
        check_word(rd, expected_status(1'b1, 1'b0, 1'b1), "status after receive");
        wb_read(reg_data, rd);
        check_word(rd, wb_data_t'(b), "received byte");
        wb_read(reg_lstatus, rd);
        check_word(rd, expected_status(1'b0, 1'b0, 1'b1), "status after data read");
        check_bit(irq, 1'b0, "irq after data read");
    endtask

    task automatic receive_frame_error();
        wb_data_t rd;
        wb_write(reg_ie, wb_data_t'(1) << st_frame_err);
        serial_send(next_random(), 1'b0);
        wait_irq("frame error");
        wb_read(reg_lstatus, rd);
        check_word(rd, expected_status(1'b0, 1'b1, 1'b1), "status after frame error");
        wb_read(reg_lstatus, rd);
        check_word(rd, expected_status(1'b0, 1'b0, 1'b1), "status after second read");
        check_bit(irq, 1'b0, "irq after status read");
    endtask

    task automatic receive_at_divisor_5();
        uart_byte_t b;
        wb_data_t   rd;
        set_divisor(5);
        wb_read(reg_baud, rd);
        check_word(rd, wb_data_t'(5), "baud rewritten");
        wb_write(reg_ie, wb_data_t'(1) << st_rx_ready);
        repeat (4) begin
            b = next_random();
            serial_send(b, 1'b1);
            wait_irq("receive at divisor 5");
            wb_read(reg_data, rd);
            check_word(rd, wb_data_t'(b), "byte at divisor 5");
        end
        check_bit(irq, 1'b0, "irq after last data read");
    endtask

    // ------------------------------
    // Clock, watchdog and sequence
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("error: watchdog expired after %0d ns, tests did not finish", watchdog_ns);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_wdata      = '0;
        rxd           = 1'b1;
        n_checks      = 0;
        n_mismatch    = 0;
        n_other       = 0;
        bit_div       = baud_reset;
        lcg_state     = 32'hf9fe;
        last_ack_time = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        reset_and_register_access();
        transmit_one_stop();
        transmit_two_stop_backpressure();
        receive_with_irq();
        receive_frame_error();
        receive_at_divisor_5();

        $display("checks %0d, mismatches %0d, other errors %0d",
                 n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: rtl/uart_top.sv
// UART peripheral top level
`timescale 1ns/10ps

module uart_top #(
    parameter int unsigned div_w = 16
) (
    input  logic               clk,
    input  logic               rst_n,

    // Wishbone classic slave
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  bus_pkg::wb_addr_t  wb_adr_i,
    input  bus_pkg::wb_data_t  wb_dat_i,
    output bus_pkg::wb_data_t  wb_dat_o,
    output logic               wb_ack_o,

    // Serial pins and interrupt
    input  logic               uart_rxd_i,
    output logic               uart_txd_o,
    output logic               uart_irq_o
);

    import uart_pkg::*;

    uart_byte_t         tx_data;
    logic               tx_valid;
    logic               tx_ready;
    logic               two_stop;
    logic [div_w-1:0]   baud_div;
    uart_byte_t         rx_data;
    logic               rx_valid;
    logic               frame_err;

    uart_regs #(
        .div_w       (div_w)
    ) u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .tx_data_o   (tx_data),
        .tx_valid_o  (tx_valid),
        .two_stop_o  (two_stop),
        .tx_ready_i  (tx_ready),
        .baud_div_o  (baud_div),
        .rx_data_i   (rx_data),
        .rx_valid_i  (rx_valid),
        .frame_err_i (frame_err),
        .irq_o       (uart_irq_o)
    );

    uart_tx #(
        .div_w       (div_w)
    ) u_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_data_i   (tx_data),
        .valid_i     (tx_valid),
        .ready_o     (tx_ready),
        .two_stop_i  (two_stop),
        .baud_div_i  (baud_div),
        .tx_pin_o    (uart_txd_o)
    );

    uart_rx #(
        .div_w       (div_w)
    ) u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_pin_i    (uart_rxd_i),
        .baud_div_i  (baud_div),
        .rx_data_o   (rx_data),
        .valid_o     (rx_valid),
        .frame_err_o (frame_err)
    );

endmodule

// File: rtl/uart_rx.sv
// UART serial receiver
`timescale 1ns/10ps

module uart_rx #(
    parameter int unsigned div_w = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rx_pin_i,
    input  logic [div_w-1:0]      baud_div_i,
    output uart_pkg::uart_byte_t  rx_data_o,
    output logic                  valid_o,
    output logic                  frame_err_o
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } rx_state_e;

    rx_state_e          state_q;
    logic               rx_meta_q;
    logic               rx_sync_q;
    logic               rx_prev_q;
    logic [div_w-1:0]   cnt_q;
    logic [2:0]         bit_idx_q;
    uart_byte_t         shift_q;
    logic               valid_q;
    logic               ferr_q;
    logic               fall;

    // ------------------------------
    // Pin synchronizer
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_pin_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    assign fall = rx_prev_q & ~rx_sync_q;

    // ------------------------------
    // Frame FSM
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= s_idle;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            valid_q   <= 1'b0;
            ferr_q    <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            ferr_q  <= 1'b0;
            case (state_q)
                s_idle: begin
                    if (fall) begin
                        // Half a bit to reach the middle of start
                        state_q <= s_start;
                        cnt_q   <= baud_div_i >> 1;
                    end
                end
                s_start: begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - div_w'(1);
                    end else if (!rx_sync_q) begin
                        state_q   <= s_data;
                        cnt_q     <= baud_div_i - div_w'(1);
                        bit_idx_q <= '0;
                    end else begin
                        // Glitch, line went back high
                        state_q <= s_idle;
                    end
                end
                s_data: begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - div_w'(1);
                    end else begin
                        cnt_q     <= baud_div_i - div_w'(1);
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= s_stop;
                        end
                    end
                end
                s_stop: begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - div_w'(1);
                    end else begin
                        valid_q <= rx_sync_q;
                        ferr_q  <= ~rx_sync_q;
                        state_q <= s_idle;
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state_q == s_data && cnt_q == '0) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
    end

    assign rx_data_o   = shift_q;
    assign valid_o     = valid_q;
    assign frame_err_o = ferr_q;

endmodule

// File: rtl/uart_tx.sv
// UART serial transmitter
`timescale 1ns/10ps

module uart_tx #(
    parameter int unsigned div_w = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  uart_pkg::uart_byte_t  tx_data_i,
    input  logic                  valid_i,
    output logic                  ready_o,
    input  logic                  two_stop_i,
    input  logic [div_w-1:0]      baud_div_i,
    output logic                  tx_pin_o
);

    import uart_pkg::*;

    logic               busy_q;
    logic               txd_q;
    logic [div_w-1:0]   cnt_q;
    logic [3:0]         bits_left_q;
    uart_byte_t         shift_q;
    logic               load;

    assign ready_o = ~busy_q;
    assign load    = valid_i & ~busy_q;

    // ------------------------------
    // Bit sequencer
    // ------------------------------

    // Bits after start, stop count fixed at load time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            txd_q       <= 1'b1;
            cnt_q       <= '0;
            bits_left_q <= '0;
        end else if (load) begin
            busy_q      <= 1'b1;
            txd_q       <= 1'b0;
            cnt_q       <= baud_div_i - div_w'(1);
            bits_left_q <= two_stop_i ? 4'd10 : 4'd9;
        end else if (busy_q) begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - div_w'(1);
            end else if (bits_left_q == '0) begin
                // Last stop bit done
                busy_q <= 1'b0;
            end else begin
                txd_q       <= shift_q[0];
                cnt_q       <= baud_div_i - div_w'(1);
                bits_left_q <= bits_left_q - 4'd1;
            end
        end
    end

    // ------------------------------
    // Data shift register
    // ------------------------------

    // Ones shift in behind the data and form the stop bits
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tx_data_i;
        end else if (busy_q && cnt_q == '0 && bits_left_q != '0) begin
            shift_q <= {1'b1, shift_q[7:1]};
        end
    end

    assign tx_pin_o = txd_q;

endmodule

// File: rtl/uart_regs.sv
// UART register block
`timescale 1ns/10ps

module uart_regs #(
    parameter int unsigned div_w = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Wishbone classic slave
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  bus_pkg::wb_addr_t     wb_adr_i,
    input  bus_pkg::wb_data_t     wb_dat_i,
    output bus_pkg::wb_data_t     wb_dat_o,
    output logic                  wb_ack_o,

    // Transmitter side
    output uart_pkg::uart_byte_t  tx_data_o,
    output logic                  tx_valid_o,
    output logic                  two_stop_o,
    input  logic                  tx_ready_i,
    output logic [div_w-1:0]      baud_div_o,

    // Receiver side
    input  uart_pkg::uart_byte_t  rx_data_i,
    input  logic                  rx_valid_i,
    input  logic                  frame_err_i,

    output logic                  irq_o
);

    import bus_pkg::*;
    import uart_pkg::*;

    uart_reg_e          reg_idx;
    logic               req;
    logic               rd_req;
    logic               wr_req;
    logic               data_wr;
    logic               accept;
    wb_data_t           rd_mux;
    uart_byte_t         status;

    logic               ack_q;
    wb_data_t           rd_data_q;
    uart_byte_t         ie_q;
    uart_byte_t         lctrl_q;
    logic [div_w-1:0]   baud_q;
    uart_byte_t         scratch_q;
    uart_byte_t         rx_data_q;
    logic               rx_ready_q;
    logic               frame_err_q;

    // ------------------------------
    // Bus decode
    // ------------------------------

    assign reg_idx = uart_reg_e'(wb_adr_i[4:2]);

    // New request only while no ack is out
    assign req    = wb_cyc_i & wb_stb_i & ~ack_q;
    assign rd_req = req & ~wb_we_i;
    assign wr_req = req & wb_we_i;

    assign data_wr = wr_req & (reg_idx == reg_data);

    // Data writes wait for the transmitter
    assign accept = req & ~(data_wr & ~tx_ready_i);

    // Byte goes straight from the bus to the transmitter
    assign tx_valid_o = data_wr;
    assign tx_data_o  = wb_dat_i[7:0];

    // ------------------------------
    // Status and read mux
    // ------------------------------

    always_comb begin
        status               = '0;
        status[st_rx_ready]  = rx_ready_q;
        status[st_frame_err] = frame_err_q;
        status[st_tx_empty]  = tx_ready_i;
        status[st_tx_idle]   = tx_ready_i;
    end

    always_comb begin
        rd_mux = '0;
        case (reg_idx)
            reg_data:    rd_mux = wb_data_t'(rx_data_q);
            reg_ie:      rd_mux = wb_data_t'(ie_q);
            reg_baud:    rd_mux = wb_data_t'(baud_q);
            reg_lctrl:   rd_mux = wb_data_t'(lctrl_q);
            reg_lstatus: rd_mux = wb_data_t'(status);
            reg_scratch: rd_mux = wb_data_t'(scratch_q);
            default:     rd_mux = '0;
        endcase
    end

    // Single cycle ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (accept && !wb_we_i) begin
            rd_data_q <= rd_mux;
        end else begin
            rd_data_q <= '0;
        end
    end

    // ------------------------------
    // Writable registers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ie_q      <= '0;
            lctrl_q   <= '0;
            baud_q    <= div_w'(baud_reset);
            scratch_q <= scratch_reset;
        end else if (wr_req) begin
            case (reg_idx)
                reg_ie:      ie_q      <= wb_dat_i[7:0];
                reg_lctrl:   lctrl_q   <= wb_dat_i[7:0];
                reg_baud:    baud_q    <= wb_dat_i[div_w-1:0];
                reg_scratch: scratch_q <= wb_dat_i[7:0];
                // Data goes to the transmitter, status is read only
                default: begin
                end
            endcase
        end
    end

    // Receive flags, a new event wins over a clearing read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_ready_q  <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            if (rx_valid_i) begin
                rx_ready_q <= 1'b1;
            end else if (rd_req && reg_idx == reg_data) begin
                rx_ready_q <= 1'b0;
            end
            if (frame_err_i) begin
                frame_err_q <= 1'b1;
            end else if (rd_req && reg_idx == reg_lstatus) begin
                frame_err_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid_i) begin
            rx_data_q <= rx_data_i;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    assign wb_ack_o   = ack_q;
    assign wb_dat_o   = rd_data_q;
    assign two_stop_o = lctrl_q[lc_two_stop];
    assign baud_div_o = baud_q;

    // Enabled status bits raise the interrupt
    assign irq_o = |(status & ie_q);

endmodule

// File: rtl/uart_pkg.sv
// UART register map and bit fields

package uart_pkg;

    // One serial data byte
    typedef logic [7:0] uart_byte_t;

    // ------------------------------
    // Register word index
    // ------------------------------

    // Taken from address bits 4 to 2
    typedef enum logic [2:0] {
        reg_data    = 3'd0,
        reg_ie      = 3'd1,
        reg_baud    = 3'd2,
        reg_lctrl   = 3'd3,
        reg_lstatus = 3'd5,
        reg_scratch = 3'd7
    } uart_reg_e;

    // ------------------------------
    // Line status bits
    // ------------------------------

    localparam int unsigned st_rx_ready  = 0;
    localparam int unsigned st_frame_err = 3;
    localparam int unsigned st_tx_empty  = 5;
    localparam int unsigned st_tx_idle   = 6;

    // Line control, two stop bits when set
    localparam int unsigned lc_two_stop = 2;

    // ------------------------------
    // Values after reset
    // ------------------------------

    localparam int unsigned baud_reset    = 8;
    localparam uart_byte_t  scratch_reset = 8'h08;

endpackage

// File: rtl/bus_pkg.sv
// Wishbone bus definitions

package bus_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------

    // Byte address width of the peripheral window
    localparam int unsigned wb_addr_w = 8;

    // Data path width
    localparam int unsigned wb_data_w = 32;

    // ------------------------------
    // Bus vector types
    // ------------------------------

    typedef logic [wb_addr_w-1:0] wb_addr_t;
    typedef logic [wb_data_w-1:0] wb_data_t;

endpackage
